// File: compile.f
logic/eth_dist_pkg.sv
logic/eth_type_classifier.sv
logic/eth_demux.sv
logic/eth_dist_regs.sv
logic/eth_dist_top.sv
sim/eth_dist_asserts.sv
sim/eth_dist_tb.sv

// File: Bender.yml
package:
  name: eth_dist

sources:
  - logic/eth_dist_pkg.sv
  - logic/eth_type_classifier.sv
  - logic/eth_demux.sv
  - logic/eth_dist_regs.sv
  - logic/eth_dist_top.sv
  - target: simulation
    files:
      - sim/eth_dist_asserts.sv
      - sim/eth_dist_tb.sv

// File: sim/eth_dist_tb.sv
// testbench for the ethernet frame distributor driving config and frames and checking every output
`timescale 1ns/1ns

module eth_dist_tb;

    import eth_dist_pkg::*;

    localparam int        M_COUNT   = 4;
    localparam eth_type_t UNMATCHED = 16'h1234;
    localparam eth_type_t TYPES [5] = '{16'h0800, 16'h86dd, 16'h0806, 16'h88cc, UNMATCHED};

    logic               clk;
    logic               rst;
    eth_hdr_t           s_hdr;
    logic               s_hdr_valid;
    logic               s_hdr_ready;
    axis_beat_t         s_beat;
    logic               s_beat_valid;
    logic               s_beat_ready;
    eth_hdr_t           m_hdr;
    logic [M_COUNT-1:0] m_hdr_valid;
    logic [M_COUNT-1:0] m_hdr_ready;
    axis_beat_t         m_beat;
    logic [M_COUNT-1:0] m_beat_valid;
    logic [M_COUNT-1:0] m_beat_ready;
    axil_addr_t         awaddr;
    logic               awvalid;
    logic               awready;
    axil_data_t         wdata;
    logic [3:0]         wstrb;
    logic               wvalid;
    logic               wready;
    axil_resp_t         bresp;
    logic               bvalid;
    logic               bready;
    axil_addr_t         araddr;
    logic               arvalid;
    logic               arready;
    axil_data_t         rdata;
    axil_resp_t         rresp;
    logic               rvalid;
    logic               rready;

    // stimulus queues and per-port expectations
    eth_hdr_t   hdr_tx_q [$];
    axis_beat_t beat_tx_q [$];
    eth_hdr_t   exp_hdr_q [M_COUNT][$];
    axis_beat_t exp_beat_q [M_COUNT][$];
    eth_type_t  tbl_type [M_COUNT];
    logic       tbl_en [M_COUNT];
    int         drops_expected = 0;
    int         beats_queued = 0;
    int         cycles = 0;
    logic [31:0] lfsr_state = 32'h5ebd;

    eth_dist_top #(
        .M_COUNT (M_COUNT)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string sig, logic [127:0] expected, logic [127:0] actual);
        $display("Fail %s expected %h got %h", sig, expected, actual);
        stop_run();
    endtask

    task automatic report_error(string what);
        $display("error: %s", what);
        stop_run();
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // lowest enabled matching entry or -1 for a dropped frame
    function automatic int expected_port(eth_type_t t);
        for (int i = 0; i < M_COUNT; i++) begin
            if (tbl_en[i] && tbl_type[i] == t) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int p = 0; p < M_COUNT; p++) begin
            n += exp_hdr_q[p].size() + exp_beat_q[p].size();
        end
        return n;
    endfunction

    task automatic axil_write(axil_addr_t addr, axil_data_t data, axil_resp_t exp_resp);
        @(posedge clk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        assert (wready) else report_error("wready did not rise together with awready");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        assert (bresp == exp_resp) else report_mismatch("bresp", exp_resp, bresp);
    endtask

    task automatic check_read(axil_addr_t addr, axil_data_t exp_data, axil_resp_t exp_resp);
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        assert (rdata == exp_data) else report_mismatch("rdata", exp_data, rdata);
        assert (rresp == exp_resp) else report_mismatch("rresp", exp_resp, rresp);
    endtask

    task automatic write_entry(int i, eth_type_t t, logic en);
        axil_write(REG_TYPE_BASE + 8'(4 * i), {15'b0, en, t}, RESP_OKAY);
        tbl_type[i] = t;
        tbl_en[i]   = en;
    endtask

    // random frame of 1 to 16 beats with expectations from the table model
    task automatic queue_frame(eth_type_t t);
        eth_hdr_t   hdr;
        axis_beat_t beat;
        int         len;
        int         port;
        hdr.dest_mac = {16'(take_bits(16)), take_bits(32)};
        hdr.src_mac  = {16'(take_bits(16)), take_bits(32)};
        hdr.eth_type = t;
        len  = int'(take_bits(4)) + 1;
        port = expected_port(t);
        hdr_tx_q.push_back(hdr);
        if (port >= 0) begin
            exp_hdr_q[port].push_back(hdr);
        end else begin
            drops_expected++;
        end
        for (int k = 0; k < len; k++) begin
            beat.tdata = 8'(take_bits(8));
            beat.tlast = (k == len - 1);
            beat.tuser = beat.tlast ? 1'(take_bits(1)) : 1'b0;
            beat_tx_q.push_back(beat);
            if (port >= 0) begin
                exp_beat_q[port].push_back(beat);
            end
        end
        beats_queued += len;
    endtask

    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = s_hdr_valid || s_beat_valid || hdr_tx_q.size() != 0 ||
                   beat_tx_q.size() != 0 || outstanding() != 0;
        end
    endtask

    initial begin : header_driver
        s_hdr       = '0;
        s_hdr_valid = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (hdr_tx_q.size() > 0) begin
                s_hdr       = hdr_tx_q.pop_front();
                s_hdr_valid = 1'b1;
                @(negedge clk);
                while (!s_hdr_ready) @(negedge clk);
            end else begin
                s_hdr_valid = 1'b0;
            end
        end
    end

    // beats go back to back and the next frame waits on the open one
    initial begin : beat_driver
        s_beat       = '0;
        s_beat_valid = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (beat_tx_q.size() > 0) begin
                s_beat       = beat_tx_q.pop_front();
                s_beat_valid = 1'b1;
                @(negedge clk);
                while (!s_beat_ready) @(negedge clk);
            end else begin
                s_beat_valid = 1'b0;
            end
        end
    end

    initial begin : back_pressure
        m_hdr_ready  = '0;
        m_beat_ready = '0;
        forever begin
            @(posedge clk);
            #1;
            m_beat_ready = M_COUNT'(take_bits(M_COUNT));
            m_hdr_ready  = M_COUNT'(take_bits(M_COUNT));
        end
    end

    // scoreboard with at most one transfer per port and cycle
    always @(negedge clk) begin
        for (int p = 0; p < M_COUNT; p++) begin
            if (m_hdr_valid[p] && m_hdr_ready[p]) begin
                assert (exp_hdr_q[p].size() > 0)
                    else report_error("unexpected header on a port");
                assert (m_hdr == exp_hdr_q[p][0])
                    else report_mismatch("m_hdr", exp_hdr_q[p][0], m_hdr);
                void'(exp_hdr_q[p].pop_front());
            end
            if (m_beat_valid[p] && m_beat_ready[p]) begin
                assert (exp_beat_q[p].size() > 0)
                    else report_error("unexpected beat on a port");
                assert (m_beat == exp_beat_q[p][0])
                    else report_mismatch("m_beat", exp_beat_q[p][0], m_beat);
                void'(exp_beat_q[p].pop_front());
            end
        end
        if (uut.u_demux.asserts_i.fail_count != 0) begin
            report_error("a concurrent assertion on the demultiplexer failed");
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 200 * beats_queued + 2000) begin
                $display("timeout: traffic did not drain in the allowed time");
                stop_run();
            end
        end
    end

    initial begin
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // register access and unmapped address
        check_read(REG_DROP_CNT, 32'h0, RESP_OKAY);
        axil_write(REG_CTRL, 32'h1, RESP_OKAY);
        for (int i = 0; i < M_COUNT; i++) begin
            write_entry(i, TYPES[i], 1'b1);
        end
        check_read(REG_CTRL, 32'h1, RESP_OKAY);
        for (int i = 0; i < M_COUNT; i++) begin
            check_read(REG_TYPE_BASE + 8'(4 * i), {15'b0, 1'b1, TYPES[i]}, RESP_OKAY);
        end
        axil_write(8'h08, 32'hffff_ffff, RESP_SLVERR);
        check_read(8'h08, 32'h0, RESP_SLVERR);

        // one frame per type then random types
        for (int t = 0; t < 5; t++) begin
            queue_frame(TYPES[t]);
        end
        for (int n = 0; n < 10; n++) begin
            queue_frame(TYPES[take_bits(3) % 5]);
        end
        wait_drain();

        // overlapping entries and a disabled one
        write_entry(3, 16'h0800, 1'b1);
        write_entry(2, 16'h0806, 1'b0);
        for (int t = 0; t < 5; t++) begin
            queue_frame(TYPES[t]);
        end
        for (int n = 0; n < 10; n++) begin
            queue_frame(TYPES[take_bits(3) % 5]);
        end
        wait_drain();
        check_read(REG_DROP_CNT, axil_data_t'(drops_expected), RESP_OKAY);

        // pending frame waits while the gate is closed
        axil_write(REG_CTRL, 32'h0, RESP_OKAY);
        queue_frame(TYPES[1]);
        repeat (20) begin
            @(negedge clk);
            assert (!s_hdr_ready && !s_beat_ready && m_hdr_valid == '0 && m_beat_valid == '0)
                else report_error("traffic moved while the distributor was disabled");
        end
        axil_write(REG_CTRL, 32'h1, RESP_OKAY);
        wait_drain();

        if (uut.u_demux.asserts_i.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

// File: sim/eth_dist_asserts.sv
// concurrent checks on the frame demultiplexer handshakes and output stability
`timescale 1ns/1ns

module eth_dist_asserts #(
    parameter int M_COUNT = 4
) (
    input logic                      clk,
    input logic                      rst,
    input logic                      enable,
    input logic                      s_hdr_valid,
    input logic                      s_hdr_ready,
    input eth_dist_pkg::axis_beat_t  s_beat,
    input logic                      s_beat_valid,
    input logic                      s_beat_ready,
    input eth_dist_pkg::eth_hdr_t    m_hdr,
    input logic [M_COUNT-1:0]        m_hdr_valid,
    input logic [M_COUNT-1:0]        m_hdr_ready,
    input eth_dist_pkg::axis_beat_t  m_beat,
    input logic [M_COUNT-1:0]        m_beat_valid,
    input logic [M_COUNT-1:0]        m_beat_ready
);

    int   fail_count = 0;
    logic open_frame;

    // frame open from header handshake to tlast handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            open_frame <= 1'b0;
        end else if (s_hdr_valid && s_hdr_ready) begin
            open_frame <= 1'b1;
        end else if (s_beat_valid && s_beat_ready && s_beat.tlast) begin
            open_frame <= 1'b0;
        end
    end

    // one port at a time
    hdr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(m_hdr_valid))
        else begin
            $error("more than one header valid bit high");
            fail_count++;
        end

    beat_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(m_beat_valid))
        else begin
            $error("more than one beat valid bit high");
            fail_count++;
        end

    // held outputs keep their valid and data
    hdr_stable: assert property (@(posedge clk) disable iff (rst)
        |(m_hdr_valid & ~m_hdr_ready) |=> $stable(m_hdr_valid) && $stable(m_hdr))
        else begin
            $error("header changed while stalled");
            fail_count++;
        end

    beat_stable: assert property (@(posedge clk) disable iff (rst)
        |(m_beat_valid & ~m_beat_ready) |=> $stable(m_beat_valid) && $stable(m_beat))
        else begin
            $error("beat changed while stalled");
            fail_count++;
        end

    hdr_blocked: assert property (@(posedge clk) disable iff (rst) open_frame |-> !s_hdr_ready)
        else begin
            $error("header ready while a frame is open");
            fail_count++;
        end

    // an idle distributor stays idle while disabled
    gate_closed: assert property (@(posedge clk) disable iff (rst)
        !enable && !(|m_hdr_valid) && !(|m_beat_valid) |=> !(|m_hdr_valid) && !(|m_beat_valid))
        else begin
            $error("traffic passed while disabled");
            fail_count++;
        end

endmodule

bind eth_demux eth_dist_asserts #(
    .M_COUNT (M_COUNT)
) asserts_i (.*);

// File: logic/eth_dist_top.sv
// ethernet frame distributor top, register block feeding classifier and demultiplexer
`timescale 1ns/1ns

module eth_dist_top #(
    parameter int M_COUNT = 4
) (
    input  logic                          clk,
    input  logic                          rst,

    // frame input
    input  eth_dist_pkg::eth_hdr_t        s_hdr,
    input  logic                          s_hdr_valid,
    output logic                          s_hdr_ready,
    input  eth_dist_pkg::axis_beat_t      s_beat,
    input  logic                          s_beat_valid,
    output logic                          s_beat_ready,

    // frame outputs
    output eth_dist_pkg::eth_hdr_t        m_hdr,
    output logic [M_COUNT-1:0]            m_hdr_valid,
    input  logic [M_COUNT-1:0]            m_hdr_ready,
    output eth_dist_pkg::axis_beat_t      m_beat,
    output logic [M_COUNT-1:0]            m_beat_valid,
    input  logic [M_COUNT-1:0]            m_beat_ready,

    // axi4-lite configuration port
    input  eth_dist_pkg::axil_addr_t      awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  eth_dist_pkg::axil_data_t      wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output eth_dist_pkg::axil_resp_t      bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  eth_dist_pkg::axil_addr_t      araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output eth_dist_pkg::axil_data_t      rdata,
    output eth_dist_pkg::axil_resp_t      rresp,
    output logic                          rvalid,
    input  logic                          rready
);

    import eth_dist_pkg::*;

    localparam int SEL_W = $clog2(M_COUNT);

    logic                       enable;
    type_entry_t [M_COUNT-1:0]  type_table;
    axil_data_t                 drop_count;
    logic [SEL_W-1:0]           select;
    logic                       drop;
    logic                       hdr_accept;

    // header handshake, drives the drop counter
    assign hdr_accept = s_hdr_valid && s_hdr_ready;

    eth_dist_regs #(
        .M_COUNT (M_COUNT)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .drop_count (drop_count),
        .enable     (enable),
        .type_table (type_table)
    );

    eth_type_classifier #(
        .M_COUNT (M_COUNT)
    ) u_classifier (
        .clk        (clk),
        .rst        (rst),
        .eth_type   (s_hdr.eth_type),
        .hdr_accept (hdr_accept),
        .type_table (type_table),
        .select     (select),
        .drop       (drop),
        .drop_count (drop_count)
    );

    eth_demux #(
        .M_COUNT (M_COUNT)
    ) u_demux (
        .clk          (clk),
        .rst          (rst),
        .s_hdr        (s_hdr),
        .s_hdr_valid  (s_hdr_valid),
        .s_hdr_ready  (s_hdr_ready),
        .s_beat       (s_beat),
        .s_beat_valid (s_beat_valid),
        .s_beat_ready (s_beat_ready),
        .m_hdr        (m_hdr),
        .m_hdr_valid  (m_hdr_valid),
        .m_hdr_ready  (m_hdr_ready),
        .m_beat       (m_beat),
        .m_beat_valid (m_beat_valid),
        .m_beat_ready (m_beat_ready),
        .enable       (enable),
        .drop         (drop),
        .select       (select)
    );

endmodule

// File: logic/eth_dist_regs.sv
// axi4-lite register block with control, ethertype table and drop counter readback
`timescale 1ns/1ns

module eth_dist_regs #(
    parameter int M_COUNT = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  eth_dist_pkg::axil_addr_t                  awaddr,
    input  logic                                      awvalid,
    output logic                                      awready,
    input  eth_dist_pkg::axil_data_t                  wdata,
    input  logic [3:0]                                wstrb,
    input  logic                                      wvalid,
    output logic                                      wready,
    output eth_dist_pkg::axil_resp_t                  bresp,
    output logic                                      bvalid,
    input  logic                                      bready,
    input  eth_dist_pkg::axil_addr_t                  araddr,
    input  logic                                      arvalid,
    output logic                                      arready,
    output eth_dist_pkg::axil_data_t                  rdata,
    output eth_dist_pkg::axil_resp_t                  rresp,
    output logic                                      rvalid,
    input  logic                                      rready,
    input  eth_dist_pkg::axil_data_t                  drop_count,
    output logic                                      enable,
    output eth_dist_pkg::type_entry_t [M_COUNT-1:0]   type_table
);

    import eth_dist_pkg::*;

    localparam int SEL_W = $clog2(M_COUNT);

    logic               aw_ready_reg;
    logic               ar_ready_reg;
    logic               wr_en;
    logic               rd_en;
    logic [M_COUNT-1:0] tbl_en;
    eth_type_t          tbl_type [M_COUNT];
    axil_data_t         rd_data;
    logic               rd_hit;

    // word-aligned table slot inside the mapped range
    function automatic logic tbl_hit(axil_addr_t addr);
        axil_addr_t off;
        off = addr - REG_TYPE_BASE;
        return (addr >= REG_TYPE_BASE) && (off[1:0] == 2'b00) && (int'(off[7:2]) < M_COUNT);
    endfunction

    function automatic logic [SEL_W-1:0] tbl_idx(axil_addr_t addr);
        axil_addr_t off;
        off = addr - REG_TYPE_BASE;
        return off[SEL_W+1:2];
    endfunction

    assign awready = aw_ready_reg;
    assign wready  = aw_ready_reg;
    assign arready = ar_ready_reg;
    assign wr_en   = aw_ready_reg && awvalid && wvalid;
    assign rd_en   = ar_ready_reg && arvalid;

    // handshake and response flags
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_ready_reg <= 1'b0;
            ar_ready_reg <= 1'b0;
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
        end else begin
            aw_ready_reg <= awvalid && wvalid && !bvalid && !aw_ready_reg;
            ar_ready_reg <= arvalid && !rvalid && !ar_ready_reg;
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            tbl_en <= '0;
        end else if (wr_en) begin
            if (awaddr == REG_CTRL && wstrb[0]) begin
                enable <= wdata[CTRL_ENABLE_BIT];
            end else if (tbl_hit(awaddr) && wstrb[2]) begin
                tbl_en[tbl_idx(awaddr)] <= wdata[TYPE_EN_BIT];
            end
        end
    end

    // ethertype values, byte strobed
    always_ff @(posedge clk) begin
        if (wr_en && tbl_hit(awaddr)) begin
            if (wstrb[0]) begin
                tbl_type[tbl_idx(awaddr)][7:0] <= wdata[7:0];
            end
            if (wstrb[1]) begin
                tbl_type[tbl_idx(awaddr)][15:8] <= wdata[15:8];
            end
        end
        if (wr_en) begin
            bresp <= (awaddr == REG_CTRL || awaddr == REG_DROP_CNT || tbl_hit(awaddr)) ?
                     RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        for (int i = 0; i < M_COUNT; i++) begin
            type_table[i].en       = tbl_en[i];
            type_table[i].eth_type = tbl_type[i];
        end
    end

    // read decode
    always_comb begin
        rd_data = '0;
        rd_hit  = 1'b1;
        if (araddr == REG_CTRL) begin
            rd_data[CTRL_ENABLE_BIT] = enable;
        end else if (araddr == REG_DROP_CNT) begin
            rd_data = drop_count;
        end else if (tbl_hit(araddr)) begin
            rd_data[15:0]        = tbl_type[tbl_idx(araddr)];
            rd_data[TYPE_EN_BIT] = tbl_en[tbl_idx(araddr)];
        end else begin
            rd_hit = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_data;
            rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// File: logic/eth_demux.sv
// ethernet frame demultiplexer, steers header and payload to one port or drops the frame
`timescale 1ns/1ns

module eth_demux #(
    parameter int M_COUNT = 4
) (
    input  logic                              clk,
    input  logic                              rst,

    // frame input
    input  eth_dist_pkg::eth_hdr_t            s_hdr,
    input  logic                              s_hdr_valid,
    output logic                              s_hdr_ready,
    input  eth_dist_pkg::axis_beat_t          s_beat,
    input  logic                              s_beat_valid,
    output logic                              s_beat_ready,

    // frame outputs, data shared across ports
    output eth_dist_pkg::eth_hdr_t            m_hdr,
    output logic [M_COUNT-1:0]                m_hdr_valid,
    input  logic [M_COUNT-1:0]                m_hdr_ready,
    output eth_dist_pkg::axis_beat_t          m_beat,
    output logic [M_COUNT-1:0]                m_beat_valid,
    input  logic [M_COUNT-1:0]                m_beat_ready,

    // control
    input  logic                              enable,
    input  logic                              drop,
    input  logic [$clog2(M_COUNT)-1:0]        select
);

    import eth_dist_pkg::*;

    localparam int SEL_W = $clog2(M_COUNT);

    // frame state
    logic [SEL_W-1:0]   select_reg;
    logic [SEL_W-1:0]   select_next;
    logic               drop_reg;
    logic               drop_next;
    logic               frame_reg;
    logic               frame_next;

    logic               hdr_ready_reg;
    logic               beat_ready_reg;
    logic               hdr_accept;
    logic               beat_accept;

    logic [M_COUNT-1:0] hdr_valid_reg;
    logic [M_COUNT-1:0] hdr_valid_next;
    eth_hdr_t           hdr_reg;

    // payload output stage
    logic [M_COUNT-1:0] beat_valid_int;
    logic [M_COUNT-1:0] out_valid_reg;
    logic [M_COUNT-1:0] out_valid_next;
    logic [M_COUNT-1:0] tmp_valid_reg;
    logic [M_COUNT-1:0] tmp_valid_next;
    axis_beat_t         out_beat_reg;
    axis_beat_t         tmp_beat_reg;
    logic               ready_int_reg;
    logic               ready_int_early;
    logic               out_taken;
    logic               store_in_to_out;
    logic               store_in_to_tmp;
    logic               store_tmp_to_out;

    assign s_hdr_ready  = hdr_ready_reg && enable;
    assign s_beat_ready = beat_ready_reg && enable;
    assign hdr_accept   = s_hdr_valid && s_hdr_ready;
    assign beat_accept  = s_beat_valid && s_beat_ready;

    assign m_hdr        = hdr_reg;
    assign m_hdr_valid  = hdr_valid_reg;
    assign m_beat       = out_beat_reg;
    assign m_beat_valid = out_valid_reg;

    always_comb begin
        select_next    = select_reg;
        drop_next      = drop_reg;
        frame_next     = frame_reg;
        hdr_valid_next = hdr_valid_reg & ~m_hdr_ready;

        // end of frame
        if (beat_accept && s_beat.tlast) begin
            frame_next = 1'b0;
            drop_next  = 1'b0;
        end

        // start of frame, latch the routing decision
        if (hdr_accept) begin
            select_next    = select;
            drop_next      = drop;
            frame_next     = 1'b1;
            hdr_valid_next = drop ? '0 : (M_COUNT'(1) << select);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            select_reg     <= '0;
            drop_reg       <= 1'b0;
            frame_reg      <= 1'b0;
            hdr_ready_reg  <= 1'b0;
            beat_ready_reg <= 1'b0;
            hdr_valid_reg  <= '0;
        end else begin
            select_reg     <= select_next;
            drop_reg       <= drop_next;
            frame_reg      <= frame_next;
            // next header only once the frame is closed and its header is gone
            hdr_ready_reg  <= !frame_next && !(|hdr_valid_next);
            // dropped frames drain at full rate
            beat_ready_reg <= (ready_int_early || drop_next) && frame_next;
            hdr_valid_reg  <= hdr_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            hdr_reg <= s_hdr;
        end
    end

    // beat heads to the latched port unless the frame is dropped
    assign beat_valid_int = (beat_accept && !drop_reg) ? (M_COUNT'(1) << select_reg) : '0;

    assign out_taken = |(m_beat_ready & out_valid_reg);

    // input may stay ready when the temp register cannot fill next cycle
    assign ready_int_early = out_taken ||
                             (!(|tmp_valid_reg) && (!(|out_valid_reg) || !(|beat_valid_int)));

    always_comb begin
        out_valid_next   = out_valid_reg;
        tmp_valid_next   = tmp_valid_reg;
        store_in_to_out  = 1'b0;
        store_in_to_tmp  = 1'b0;
        store_tmp_to_out = 1'b0;

        if (ready_int_reg) begin
            if (out_taken || !(|out_valid_reg)) begin
                out_valid_next  = beat_valid_int;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_valid_next  = beat_valid_int;
                store_in_to_tmp = 1'b1;
            end
        end else if (out_taken) begin
            out_valid_next   = tmp_valid_reg;
            tmp_valid_next   = '0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= '0;
            tmp_valid_reg <= '0;
            ready_int_reg <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            tmp_valid_reg <= tmp_valid_next;
            ready_int_reg <= ready_int_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat_reg <= s_beat;
        end else if (store_tmp_to_out) begin
            out_beat_reg <= tmp_beat_reg;
        end

        if (store_in_to_tmp) begin
            tmp_beat_reg <= s_beat;
        end
    end

endmodule

// File: logic/eth_type_classifier.sv
// ethertype classifier, picks an output port per header and counts dropped frames
`timescale 1ns/1ns

module eth_type_classifier #(
    parameter int M_COUNT = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  eth_dist_pkg::eth_type_t                   eth_type,
    input  logic                                      hdr_accept,
    input  eth_dist_pkg::type_entry_t [M_COUNT-1:0]   type_table,
    output logic [$clog2(M_COUNT)-1:0]                select,
    output logic                                      drop,
    output eth_dist_pkg::axil_data_t                  drop_count
);

    localparam int SEL_W = $clog2(M_COUNT);

    logic hit;

    // priority match, lowest index wins
    always_comb begin
        hit    = 1'b0;
        select = '0;
        for (int i = 0; i < M_COUNT; i++) begin
            if (!hit && type_table[i].en && type_table[i].eth_type == eth_type) begin
                hit    = 1'b1;
                select = SEL_W'(i);
            end
        end
    end

    // nothing enabled matched
    assign drop = !hit;

    // saturating drop counter
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (hdr_accept && drop && drop_count != '1) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

// File: logic/eth_dist_pkg.sv
// ethernet frame distributor shared types, widths and register map
package eth_dist_pkg;

    // widths that carry a meaning
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // frame header as presented on the header channel
    typedef struct packed {
        mac_addr_t dest_mac;
        mac_addr_t src_mac;
        eth_type_t eth_type;
    } eth_hdr_t;

    // one payload byte with its sideband
    // tuser flags a bad frame and travels untouched
    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
        logic       tuser;
    } axis_beat_t;

    // one ethertype table entry
    typedef struct packed {
        logic      en;
        eth_type_t eth_type;
    } type_entry_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // register offsets
    localparam axil_addr_t REG_CTRL      = 8'h00;
    localparam axil_addr_t REG_DROP_CNT  = 8'h04;
    localparam axil_addr_t REG_TYPE_BASE = 8'h10;

    // bit positions inside the registers
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int TYPE_EN_BIT     = 16;

endpackage
